// File: src/fetch_defines.svh
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Number of byte entries held in the instruction stream FIFO
`define FETCH_FIFO_DEPTH 6

// The FIFO reports full two entries before it really is full.
// A word read that has already been issued can still deliver two bytes
// after the prefetcher has seen full, so those two slots must stay free
`define FETCH_FIFO_FULL_THRESHOLD (`FETCH_FIFO_DEPTH - 2)

// Code segment loaded at reset, the offset resets to zero
`define FETCH_RESET_CS 16'hffff

`endif

// File: src/fetch_pkg.sv
`default_nettype none

// Vector types shared between the fetch front end and its environment
package fetch_pkg;

    // Segment register value, shifted left by four to form a base address
    typedef logic [15:0] seg_t;

    // Offset within the code segment, wraps at 16 bits
    typedef logic [15:0] offset_t;

    // Address of a 16-bit memory word.
    // This is bits 19:1 of the 20-bit physical address
    typedef logic [19:1] word_addr_t;

    // Data word returned by the memory bus
    typedef logic [15:0] mem_word_t;

    // One byte of the instruction stream
    typedef logic [7:0] insn_byte_t;

endpackage

`default_nettype wire

// File: src/insn_fifo.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defines.svh"

// Instruction stream FIFO
//
// Circular byte buffer between the prefetcher and the decoder. The head
// entry is always on rd_data while empty is low, a read moves to the next
// entry on the clock edge. Flush drops everything in one cycle and wins
// over a write in the same cycle
module insn_fifo #(
    parameter int depth = `FETCH_FIFO_DEPTH
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,

    // Write side from the prefetcher
    input  logic                  wr_en,
    input  fetch_pkg::insn_byte_t wr_data,

    // Read side to the consumer
    input  logic                  rd_en,
    output fetch_pkg::insn_byte_t rd_data,
    output logic                  empty,
    output logic                  full
);

    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    typedef logic [ptr_w-1:0] ptr_t;
    typedef logic [count_w-1:0] count_t;

    fetch_pkg::insn_byte_t mem [depth];

    ptr_t   rd_ptr;
    ptr_t   wr_ptr;
    count_t count;

    logic   push;
    logic   pop;

    // Depth need not be a power of two, so pointers wrap by compare
    function automatic ptr_t ptr_inc(input ptr_t ptr);
        return (ptr == ptr_t'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // A write into a completely full buffer would overwrite the head
    assign push = wr_en && (count != count_t'(depth));
    assign pop = rd_en && !empty;

    assign rd_data = mem[rd_ptr];
    assign empty = (count == '0);

    // Raised early so that a word already being fetched still fits
    assign full = (count >= count_t'(`FETCH_FIFO_FULL_THRESHOLD));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else if (flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end

            // Simultaneous push and pop leave the occupancy where it is
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push && !flush) begin
            mem[wr_ptr] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// File: src/prefetch.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defines.svh"

// Instruction prefetcher
//
// Holds the current CS and the offset of the next byte to be pushed into
// the instruction stream FIFO. Words are read from memory one at a time and
// split into bytes, the low byte goes out in the acknowledge cycle and the
// high byte in the cycle after. A fetch starting at an odd offset only
// delivers the high byte of its word.
//
// Loading a new CS:IP always flushes the FIFO. If a read is outstanding at
// that time the new address is parked and the read is marked as aborted,
// its data is thrown away when it completes and the FIFO is flushed again
module prefetch (
    input  logic                  clk,
    input  logic                  reset,

    // New CS:IP from the execution side, valid with the load strobe
    input  fetch_pkg::seg_t       new_cs,
    input  fetch_pkg::offset_t    new_ip,
    input  logic                  load_new_ip,

    // Write side of the instruction stream FIFO
    output logic                  fifo_wr_en,
    output fetch_pkg::insn_byte_t fifo_wr_data,
    output logic                  fifo_flush,
    input  logic                  fifo_full,

    // Memory read port
    output logic                  mem_access,
    input  logic                  mem_ack,
    output fetch_pkg::word_addr_t mem_address,
    input  fetch_pkg::mem_word_t  mem_data
);

    // Idle waits for FIFO space, wait has a read on the bus and second
    // pushes the saved high byte of an even-aligned word
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_WAIT,
        FETCH_SECOND
    } fetch_state_t;

    fetch_state_t          state_q;
    fetch_state_t          state_d;

    // Current code segment and offset of the next byte to write
    fetch_pkg::seg_t       cs_q;
    fetch_pkg::seg_t       cs_d;
    fetch_pkg::offset_t    ip_q;
    fetch_pkg::offset_t    ip_d;
    fetch_pkg::offset_t    ip_plus_one;

    // Set while the outstanding read belongs to a stream that was replaced
    logic                  abort_q;
    logic                  abort_d;

    // Most recent CS:IP load, used when an aborted read completes
    fetch_pkg::seg_t       saved_cs;
    fetch_pkg::offset_t    saved_ip;

    // High half of the last word, written in the cycle after the ack
    fetch_pkg::insn_byte_t high_byte;

    fetch_pkg::word_addr_t addr_d;

    logic                  ack_write;
    logic                  take_new;
    logic                  defer_new;
    logic                  abort_done;
    logic                  redirect;
    logic                  byte_write;
    fetch_pkg::seg_t       redirect_cs;
    fetch_pkg::offset_t    redirect_ip;

    // Word address of CS:IP, the segment base is always even so the
    // offset's bit 0 only selects the byte lane
    function automatic fetch_pkg::word_addr_t word_addr(input fetch_pkg::seg_t seg,
                                                        input fetch_pkg::offset_t off);
        return {seg, 3'b000} + {4'b0000, off[15:1]};
    endfunction

    // The request drops in the ack cycle so it never looks like a new read
    assign mem_access = (state_q == FETCH_WAIT) && !mem_ack;

    assign ack_write = (state_q == FETCH_WAIT) && mem_ack;

    // With nothing in flight a load takes effect straight away.
    // An ack in the same cycle ends the read, so that counts as not in flight
    assign take_new = load_new_ip && !mem_access;
    assign defer_new = load_new_ip && mem_access;
    assign abort_done = abort_q && ack_write;
    assign redirect = take_new || abort_done;

    // A load in the same cycle as the aborted ack is newer than the parked one
    assign redirect_cs = load_new_ip ? new_cs : saved_cs;
    assign redirect_ip = load_new_ip ? new_ip : saved_ip;

    // Bytes are only pushed for the live stream
    assign byte_write = !redirect && (ack_write || state_q == FETCH_SECOND);

    assign fifo_wr_en = byte_write;
    assign fifo_flush = load_new_ip || abort_done;

    // Odd offsets take the upper lane of the word on the bus
    assign fifo_wr_data = (state_q == FETCH_SECOND) ? high_byte :
                          ip_q[0] ? mem_data[15:8] : mem_data[7:0];

    // Offset arithmetic stays inside the segment
    assign ip_plus_one = ip_q + 16'd1;

    always_comb begin
        state_d = state_q;
        cs_d = cs_q;
        ip_d = ip_q;
        abort_d = abort_q;
        addr_d = mem_address;

        if (redirect) begin
            // The FIFO is flushed in this cycle so a new read can start at once
            state_d = FETCH_WAIT;
            cs_d = redirect_cs;
            ip_d = redirect_ip;
            abort_d = 1'b0;
            addr_d = word_addr(redirect_cs, redirect_ip);
        end else if (defer_new) begin
            abort_d = 1'b1;
        end else if (byte_write) begin
            ip_d = ip_plus_one;
            if (ack_write && !ip_q[0]) begin
                state_d = FETCH_SECOND;
            end else if (!fifo_full) begin
                // Last byte of the word, the next read follows directly
                state_d = FETCH_WAIT;
                addr_d = word_addr(cs_q, ip_plus_one);
            end else begin
                state_d = FETCH_IDLE;
            end
        end else if (state_q == FETCH_IDLE && !fifo_full) begin
            state_d = FETCH_WAIT;
            addr_d = word_addr(cs_q, ip_q);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= FETCH_IDLE;
            cs_q <= `FETCH_RESET_CS;
            ip_q <= '0;
            abort_q <= 1'b0;
        end else begin
            state_q <= state_d;
            cs_q <= cs_d;
            ip_q <= ip_d;
            abort_q <= abort_d;
        end
    end

    // Only changes on entry to the wait state, so it holds for the whole read
    always_ff @(posedge clk) begin
        mem_address <= addr_d;
    end

    always_ff @(posedge clk) begin
        if (load_new_ip) begin
            saved_cs <= new_cs;
            saved_ip <= new_ip;
        end
    end

    always_ff @(posedge clk) begin
        if (ack_write) begin
            high_byte <= mem_data[15:8];
        end
    end

endmodule

`default_nettype wire

// File: src/fetch_unit.sv
`default_nettype none
`timescale 1ns/1ps

// Instruction fetch front end
//
// The prefetcher reads words over the memory port and feeds bytes into
// the instruction stream FIFO, the consumer pops them from the read side
module fetch_unit (
    input  logic                  clk,
    input  logic                  reset,

    // Branch target
    input  fetch_pkg::seg_t       new_cs,
    input  fetch_pkg::offset_t    new_ip,
    input  logic                  load_new_ip,

    // Memory bus
    output logic                  mem_access,
    input  logic                  mem_ack,
    output fetch_pkg::word_addr_t mem_address,
    input  fetch_pkg::mem_word_t  mem_data,

    // Byte stream to the consumer
    input  logic                  rd_en,
    output fetch_pkg::insn_byte_t rd_data,
    output logic                  empty
);

    // Prefetcher to FIFO write port
    logic                  fifo_wr_en;
    fetch_pkg::insn_byte_t fifo_wr_data;
    logic                  fifo_flush;
    logic                  fifo_full;

    prefetch u_prefetch (
        .clk          (clk),
        .reset        (reset),
        .new_cs       (new_cs),
        .new_ip       (new_ip),
        .load_new_ip  (load_new_ip),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .fifo_flush   (fifo_flush),
        .fifo_full    (fifo_full),
        .mem_access   (mem_access),
        .mem_ack      (mem_ack),
        .mem_address  (mem_address),
        .mem_data     (mem_data)
    );

    // Depth comes from the default, which follows the shared define
    insn_fifo u_fifo (
        .clk     (clk),
        .reset   (reset),
        .flush   (fifo_flush),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (rd_en),
        .rd_data (rd_data),
        .empty   (empty),
        .full    (fifo_full)
    );

endmodule

`default_nettype wire

// File: verification/fetch_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defines.svh"

// Protocol assertions for the fetch front end that are bound into fetch_unit
module fetch_checker (
    input logic                  clk,
    input logic                  reset,
    input logic                  mem_access,
    input logic                  mem_ack,
    input fetch_pkg::word_addr_t mem_address,
    input logic                  fifo_wr_en,
    input logic                  fifo_flush,
    input logic                  rd_en,
    input logic                  empty
);

    // Occupancy rebuilt from the FIFO's own write, flush and pop strobes
    int occupancy;

    // Number of assertion failures seen so far
    int failures = 0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupancy <= 0;
        end else if (fifo_flush) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + (fifo_wr_en ? 1 : 0) - ((rd_en && !empty) ? 1 : 0);
        end
    end

    // Two high cycles in a row are always the same read
    address_stable: assert property (@(posedge clk) disable iff (reset)
        (mem_access && $past(mem_access)) |-> (mem_address == $past(mem_address)))
        else begin
            $error("mem_address moved while a read was pending");
            failures++;
        end

    // The request must drop with the acknowledge and stay low in reset
    access_low: assert property (@(posedge clk) (mem_ack || reset) |-> !mem_access)
        else begin
            $error("mem_access high during an acknowledge or in reset");
            failures++;
        end

    no_overflow: assert property (@(posedge clk) disable iff (reset)
        (fifo_wr_en && !fifo_flush) |-> (occupancy < `FETCH_FIFO_DEPTH))
        else begin
            $error("FIFO write while the FIFO holds its full depth");
            failures++;
        end

endmodule

`default_nettype wire

// File: verification/fetch_monitor.sv
`default_nettype none
`timescale 1ns/1ps

`include "fetch_defines.svh"

// Watches the consumer side of the fetch unit and compares every popped
// byte with the byte rule for the stream that is currently under test
module fetch_monitor (
    input logic                  clk,
    input logic                  reset,
    input logic                  rd_en,
    input logic                  empty,
    input fetch_pkg::insn_byte_t rd_data
);

    int error_count = 0;
    int test_count = 0;
    int failed_tests = 0;

    // The stream that the current test expects
    string                 test_name = "";
    fetch_pkg::seg_t       cs = '0;
    fetch_pkg::offset_t    ip = '0;
    int                    length = 0;
    int                    popped = 0;
    int                    test_errors = 0;
    bit                    active = 1'b0;
    fetch_pkg::insn_byte_t expected;

    // Byte k of a stream with the offset wrapping inside the segment.
    // Memory holds the low 8 bits of the physical address XOR 8'h5a
    function automatic fetch_pkg::insn_byte_t stream_byte(input fetch_pkg::seg_t seg,
                                                          input fetch_pkg::offset_t off,
                                                          input int k);
        fetch_pkg::offset_t off_k;
        logic [19:0]        phys;
        off_k = off + 16'(k);
        phys = {seg, 4'h0} + {4'h0, off_k};
        return phys[7:0] ^ 8'h5a;
    endfunction

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic begin_test(input string name, input fetch_pkg::seg_t seg,
                              input fetch_pkg::offset_t off, input int len,
                              input bit from_reset);
        test_name = name;
        // After reset the prefetcher runs from the reset segment at offset 0
        cs = from_reset ? `FETCH_RESET_CS : seg;
        ip = from_reset ? 16'h0000 : off;
        length = len;
        popped = 0;
        test_errors = 0;
        active = 1'b1;
    endtask

    // Called one cycle after a load, when the flush must have emptied the FIFO
    task automatic expect_flushed();
        if (empty !== 1'b1) begin
            $display("mismatch at %0t: empty expected 1 got %b (%s)", $time, empty, test_name);
            note_error();
        end
    endtask

    task automatic end_test();
        active = 1'b0;
        test_count++;
        if (popped != length) begin
            $display("%s consumed %0d of %0d bytes", test_name, popped, length);
            note_error();
        end
        if (test_errors == 0) begin
            $display("%s cs=%h ip=%h bytes=%0d ok", test_name, cs, ip, length);
        end else begin
            $display("%s cs=%h ip=%h bytes=%0d: %0d errors", test_name, cs, ip, length,
                     test_errors);
            failed_tests++;
        end
    endtask

    task automatic report_counts(input int assertion_failures);
        $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
                 test_count, failed_tests, error_count, assertion_failures);
    endtask

    // A pop happens on the edge where rd_en is seen with data present
    always @(posedge clk) begin
        if (!reset && rd_en && !empty) begin
            if (!active) begin
                $display("error at %0t: a byte was popped while no test was running", $time);
                error_count++;
            end else begin
                expected = stream_byte(cs, ip, popped);
                if (rd_data !== expected) begin
                    $display("mismatch at %0t: rd_data expected %h got %h (%s byte %0d)",
                             $time, expected, rd_data, test_name, popped);
                    note_error();
                end
                popped++;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/fetch_tb.sv
`default_nettype none
`timescale 1ns/1ps

// Testbench for the fetch front end. It plays the memory and the byte
// consumer, and runs one test per line of the pattern file
module fetch_tb;

    logic clk = 1'b0;
    logic reset = 1'b1;

    fetch_pkg::seg_t       new_cs = '0;
    fetch_pkg::offset_t    new_ip = '0;
    logic                  load_new_ip = 1'b0;
    logic                  mem_ack = 1'b0;
    fetch_pkg::mem_word_t  mem_data = '0;
    logic                  rd_en = 1'b0;

    logic                  mem_access;
    fetch_pkg::word_addr_t mem_address;
    fetch_pkg::insn_byte_t rd_data;
    logic                  empty;

    // Memory model whose latency comes from the current pattern line
    int latency = 2;
    int wait_left = 0;
    bit busy = 1'b0;

    // Set when a wait runs out or the pattern file is missing
    bit stopped = 1'b0;
    int test_num = 0;

    always #5 clk = ~clk;

    fetch_unit u_dut (
        .clk         (clk),
        .reset       (reset),
        .new_cs      (new_cs),
        .new_ip      (new_ip),
        .load_new_ip (load_new_ip),
        .mem_access  (mem_access),
        .mem_ack     (mem_ack),
        .mem_address (mem_address),
        .mem_data    (mem_data),
        .rd_en       (rd_en),
        .rd_data     (rd_data),
        .empty       (empty)
    );

    fetch_monitor u_monitor (
        .clk     (clk),
        .reset   (reset),
        .rd_en   (rd_en),
        .empty   (empty),
        .rd_data (rd_data)
    );

    bind fetch_unit fetch_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .mem_access  (mem_access),
        .mem_ack     (mem_ack),
        .mem_address (mem_address),
        .fifo_wr_en  (fifo_wr_en),
        .fifo_flush  (fifo_flush),
        .rd_en       (rd_en),
        .empty       (empty)
    );

    // Word A holds physical bytes 2A and 2A+1, each its address XOR 8'h5a
    function automatic fetch_pkg::mem_word_t word_data(input fetch_pkg::word_addr_t addr);
        return {({addr[7:1], 1'b1} ^ 8'h5a), ({addr[7:1], 1'b0} ^ 8'h5a)};
    endfunction

    // Each read is answered after latency plus up to two extra cycles.
    // The acknowledge is a single cycle pulse with the data
    always @(negedge clk) begin
        if (reset) begin
            mem_ack = 1'b0;
            busy = 1'b0;
        end else if (mem_ack) begin
            mem_ack = 1'b0;
        end else if (mem_access) begin
            if (!busy) begin
                busy = 1'b1;
                wait_left = latency + int'($urandom % 3);
            end
            if (wait_left == 0) begin
                mem_data = word_data(mem_address);
                mem_ack = 1'b1;
                busy = 1'b0;
            end else begin
                wait_left--;
            end
        end
    end

    // Waits on falling edges for a pending read or for data to pop
    task automatic wait_until(input bit for_request, input string what);
        int cycles;
        cycles = 0;
        while (!(for_request ? mem_access : !empty) && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!(for_request ? mem_access : !empty)) begin
            $display("timeout at %0t: %s", $time, what);
            stopped = 1'b1;
        end
    endtask

    task automatic load_address(input fetch_pkg::seg_t cs, input fetch_pkg::offset_t ip);
        new_cs = cs;
        new_ip = ip;
        load_new_ip = 1'b1;
        @(negedge clk);
        load_new_ip = 1'b0;
    endtask

    // Pops n bytes with short random gaps and one long pause halfway,
    // long enough for the FIFO to fill and the prefetcher to stall
    task automatic consume(input int n);
        int pause;
        for (int k = 0; k < n; k++) begin
            wait_until(1'b0, "no byte arrived in the FIFO");
            if (stopped) return;
            rd_en = 1'b1;
            @(negedge clk);
            rd_en = 1'b0;
            pause = (k == n / 2) ? 30 + int'($urandom % 20) : int'($urandom % 3);
            repeat (pause) @(negedge clk);
        end
    endtask

    task automatic run_test(input fetch_pkg::seg_t cs, input fetch_pkg::offset_t ip,
                            input int n, input int mode);
        string name;
        name = $sformatf("test %0d", test_num);
        if (mode == 2) begin
            u_monitor.begin_test(name, cs, ip, n, 1'b1);
        end else begin
            if (mode == 1) begin
                // Start a throwaway stream and jump while its read is pending
                load_address(cs ^ 16'h0f0f, ip ^ 16'h1234);
                wait_until(1'b1, "no read started after the first load");
                if (stopped) return;
                @(negedge clk);
            end
            u_monitor.begin_test(name, cs, ip, n, 1'b0);
            load_address(cs, ip);
            u_monitor.expect_flushed();
        end
        consume(n);
        if (stopped) return;
        u_monitor.end_test();
    endtask

    initial begin
        int                 fd;
        int                 n;
        int                 lat;
        int                 mode;
        string              line;
        fetch_pkg::seg_t    cs;
        fetch_pkg::offset_t ip;
        void'($urandom(32'h71ad_6b33));
        repeat (4) @(negedge clk);
        reset = 1'b0;

        fd = $fopen("verification/fetch_patterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file");
            stopped = 1'b1;
        end
        while (!stopped && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Blank lines and comment lines carry no test
            if (line.len() > 1 && line.getc(0) != "#") begin
                if ($sscanf(line, "%h %h %d %d %d", cs, ip, n, lat, mode) == 5) begin
                    test_num++;
                    latency = lat;
                    run_test(cs, ip, n, mode);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        u_monitor.report_counts(u_dut.u_checker.failures);
        if (stopped || u_monitor.error_count != 0 || u_monitor.test_count == 0 ||
            u_dut.u_checker.failures != 0) begin
            $display("*** TEST FAILED ***");
        end else begin
            $display("*** TEST PASSED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+src
src/fetch_pkg.sv
src/insn_fifo.sv
src/prefetch.sv
src/fetch_unit.sv
verification/fetch_checker.sv
verification/fetch_monitor.sv
verification/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compiles the fetch testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module fetch_tb --Mdir obj_dir -o fetch_sim || exit 1

./obj_dir/fetch_sim | tee /dev/stderr | grep -F '*** TEST PASSED ***' > /dev/null && exit 0 || exit 1

// File: verification/fetch_patterns.txt
# Columns: CS (hex), IP (hex), bytes to consume, memory latency in cycles, mode
# Mode 0 loads CS:IP, 1 jumps to CS:IP while a slow read is pending, 2 runs from reset
ffff 0000 12 1 2
1234 0100 16 0 0
1234 0101 13 0 0
0800 0037 9 3 0
0f00 fffe 10 1 0
0f00 ffff 6 4 0
2000 0040 40 0 0
2000 00a1 30 2 0
3c3c 0200 12 9 1
3c3c 0203 12 12 1
abcd 7ffe 24 1 0
0000 0000 20 0 0
fff0 fff8 20 2 0
5a5a 1111 8 10 1
0001 fffd 16 0 0
beef 0002 4 5 0
